// ==== Makefile ====
# Verilator build, run and lint for the SRAM bank testbench.
VERILATOR ?= verilator
TOP       ?= sms_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/sms_ahb_ctrl.sv ====
// AHB-Lite transfer control for the SRAM bank.
// Reads go to the SRAM in their address phase; writes are buffered and
// committed in their data phase with the live hwdata. A read that meets
// a buffered write is parked in the same holding registers and replayed
// one cycle later, with hready held low for that cycle.
`timescale 1ns/1ps

module sms_ahb_ctrl (
  input  logic                i_sys_hclk,
  input  logic                i_sys_rst_b,
  input  logic                i_hsel,
  input  sms_pkg::htrans_t    i_htrans,
  input  logic                i_hwrite,
  input  sms_pkg::hsize_t     i_hsize,
  input  sms_pkg::haddr_t     i_haddr,
  input  sms_pkg::hdata_t     i_hwdata,
  input  logic                i_bus_hready,
  output logic                o_hready,
  output sms_pkg::hresp_t     o_hresp,
  output logic                o_ram_sel,
  output logic                o_ram_write,
  output sms_pkg::hsize_t     o_ram_size,
  output sms_pkg::bank_addr_t o_ram_addr,
  output sms_pkg::hdata_t     o_ram_wdata,
  output logic                o_idle
);

  logic                addr_acc;
  logic                acc_wr;
  logic                acc_rd;
  logic                wr_pend_q;     // Write data phase in this cycle.
  logic                replay_q;      // Parked read issues in this cycle.
  logic                rd_collide;
  logic                buf_issue;
  sms_pkg::hsize_t     buf_size_q;
  sms_pkg::bank_addr_t buf_addr_q;

  assign addr_acc = i_hsel && i_bus_hready &&
                    ((i_htrans == sms_pkg::HTRANS_NONSEQ) ||
                     (i_htrans == sms_pkg::HTRANS_SEQ));
  assign acc_wr = addr_acc && i_hwrite;
  assign acc_rd = addr_acc && !i_hwrite;

  // The buffered write owns the SRAM port, so the read waits a cycle.
  assign rd_collide = wr_pend_q && acc_rd;
  assign buf_issue  = wr_pend_q || replay_q;

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      wr_pend_q <= 1'b0;
      replay_q  <= 1'b0;
    end
    else
    begin
      wr_pend_q <= acc_wr;
      replay_q  <= rd_collide;
    end
  end

  // Shared holding registers for a buffered write or a parked read.
  always_ff @(posedge i_sys_hclk)
  begin
    if (acc_wr || rd_collide)
    begin
      buf_size_q <= i_hsize;
      buf_addr_q <= i_haddr[sms_pkg::BANK_AW-1:0];
    end
  end

  // SRAM request mux. Buffered accesses win over a live read.
  always_comb
  begin
    if (buf_issue)
    begin
      o_ram_sel   = 1'b1;
      o_ram_write = wr_pend_q;
      o_ram_size  = buf_size_q;
      o_ram_addr  = buf_addr_q;
    end
    else
    begin
      o_ram_sel   = acc_rd;
      o_ram_write = 1'b0;
      o_ram_size  = i_hsize;
      o_ram_addr  = i_haddr[sms_pkg::BANK_AW-1:0];
    end
  end

  assign o_ram_wdata = i_hwdata;   // Only sampled on a buffered write.

  assign o_hready = !replay_q;
  assign o_hresp  = sms_pkg::HRESP_OKAY;
  assign o_idle   = !addr_acc && !buf_issue;

  a_replay_single: assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    replay_q |=> !replay_q
  );

endmodule

// ==== rtl/sms_bank_top.sv ====
// Top level of the 64 KB AHB-Lite SRAM bank.
// Chains the deny filter, the transfer controller and the SRAM array.
// The slave is alone on its bus, so o_hready also serves as bus hready.
`timescale 1ns/1ps

module sms_bank_top (
  input  logic             i_sys_hclk,
  input  logic             i_sys_rst_b,
  input  logic             i_hsel,
  input  sms_pkg::htrans_t i_htrans,
  input  logic             i_hwrite,
  input  sms_pkg::hsize_t  i_hsize,
  input  sms_pkg::haddr_t  i_haddr,
  input  sms_pkg::hdata_t  i_hwdata,
  input  logic             i_rd_deny,
  input  logic             i_wr_deny,
  output sms_pkg::hdata_t  o_hrdata,
  output logic             o_hready,
  output sms_pkg::hresp_t  o_hresp,
  output logic             o_idle
);

  logic                filt_hsel;
  sms_pkg::htrans_t    filt_htrans;
  logic                ctrl_hready;
  sms_pkg::hresp_t     ctrl_hresp;
  logic                ram_sel;
  logic                ram_write;
  sms_pkg::hsize_t     ram_size;
  sms_pkg::bank_addr_t ram_addr;
  sms_pkg::hdata_t     ram_wdata;
  sms_pkg::hdata_t     ram_rdata;

  sms_deny_filter u_deny_filter (
    .i_sys_hclk    (i_sys_hclk),
    .i_sys_rst_b   (i_sys_rst_b),
    .i_hsel        (i_hsel),
    .i_htrans      (i_htrans),
    .i_hwrite      (i_hwrite),
    .i_rd_deny     (i_rd_deny),
    .i_wr_deny     (i_wr_deny),
    .i_ctrl_hready (ctrl_hready),
    .i_ctrl_hresp  (ctrl_hresp),
    .o_filt_hsel   (filt_hsel),
    .o_filt_htrans (filt_htrans),
    .o_hready      (o_hready),
    .o_hresp       (o_hresp)
  );

  sms_ahb_ctrl u_ahb_ctrl (
    .i_sys_hclk   (i_sys_hclk),
    .i_sys_rst_b  (i_sys_rst_b),
    .i_hsel       (filt_hsel),
    .i_htrans     (filt_htrans),
    .i_hwrite     (i_hwrite),
    .i_hsize      (i_hsize),
    .i_haddr      (i_haddr),
    .i_hwdata     (i_hwdata),
    .i_bus_hready (o_hready),     // Final bus hready for phase tracking.
    .o_hready     (ctrl_hready),
    .o_hresp      (ctrl_hresp),
    .o_ram_sel    (ram_sel),
    .o_ram_write  (ram_write),
    .o_ram_size   (ram_size),
    .o_ram_addr   (ram_addr),
    .o_ram_wdata  (ram_wdata),
    .o_idle       (o_idle)
  );

  sms_sram_bank u_sram_bank (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_ram_sel   (ram_sel),
    .i_ram_write (ram_write),
    .i_ram_size  (ram_size),
    .i_ram_addr  (ram_addr),
    .i_ram_wdata (ram_wdata),
    .o_ram_rdata (ram_rdata)
  );

  assign o_hrdata = ram_rdata;

endmodule

// ==== rtl/sms_deny_filter.sv ====
// Region deny filter in front of the SRAM bank controller.
// A transfer whose direction is denied never reaches the controller;
// the filter answers it with the two-cycle AHB ERROR response instead
// and otherwise passes the controller's hready and hresp through.
`timescale 1ns/1ps

module sms_deny_filter (
  input  logic             i_sys_hclk,
  input  logic             i_sys_rst_b,
  input  logic             i_hsel,
  input  sms_pkg::htrans_t i_htrans,
  input  logic             i_hwrite,
  input  logic             i_rd_deny,
  input  logic             i_wr_deny,
  input  logic             i_ctrl_hready,
  input  sms_pkg::hresp_t  i_ctrl_hresp,
  output logic             o_filt_hsel,
  output sms_pkg::htrans_t o_filt_htrans,
  output logic             o_hready,
  output sms_pkg::hresp_t  o_hresp
);

  sms_pkg::deny_state_e state_q;
  sms_pkg::deny_state_e state_nxt;
  logic                 addr_acc;
  logic                 deny_hit;

  assign addr_acc = i_hsel && o_hready &&
                    ((i_htrans == sms_pkg::HTRANS_NONSEQ) ||
                     (i_htrans == sms_pkg::HTRANS_SEQ));
  assign deny_hit = addr_acc && (i_hwrite ? i_wr_deny : i_rd_deny);

  assign o_filt_hsel   = deny_hit ? 1'b0 : i_hsel;
  assign o_filt_htrans = deny_hit ? '0 : i_htrans;   // Shows IDLE to the controller.

  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      sms_pkg::DENY_IDLE:
      begin
        if (deny_hit)
          state_nxt = sms_pkg::DENY_ERR_WAIT;
      end
      sms_pkg::DENY_ERR_WAIT:
        state_nxt = sms_pkg::DENY_ERR_LAST;
      sms_pkg::DENY_ERR_LAST:
      begin
        // hready is high here, so a new denied transfer may start.
        state_nxt = deny_hit ? sms_pkg::DENY_ERR_WAIT : sms_pkg::DENY_IDLE;
      end
      default:
        state_nxt = sms_pkg::DENY_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      state_q <= sms_pkg::DENY_IDLE;
    else
      state_q <= state_nxt;
  end

  always_comb
  begin
    case (state_q)
      sms_pkg::DENY_ERR_WAIT:
      begin
        o_hready = 1'b0;                   // First ERROR cycle.
        o_hresp  = sms_pkg::HRESP_ERROR;
      end
      sms_pkg::DENY_ERR_LAST:
      begin
        o_hready = 1'b1;                   // Last ERROR cycle.
        o_hresp  = sms_pkg::HRESP_ERROR;
      end
      default:
      begin
        o_hready = i_ctrl_hready;
        o_hresp  = i_ctrl_hresp;
      end
    endcase
  end

  a_err_two_cycles: assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    (state_q == sms_pkg::DENY_ERR_WAIT) |=> (state_q == sms_pkg::DENY_ERR_LAST)
  );

endmodule

// ==== rtl/sms_pkg.sv ====
// Shared definitions for the 64 KB AHB-Lite SRAM bank.
// Every RTL file refers to these by sms_pkg:: scoped names.
// Holds bus and array widths, AHB encodings, vector types and the
// state type of the deny response FSM.
package sms_pkg;

  localparam int DATA_W    = 32;      // AHB data bus width.
  localparam int BANK_AW   = 16;      // Byte offset inside the 64 KB bank.
  localparam int RAM_AW    = 14;      // Word index of the array.
  localparam int RAM_DEPTH = 16384;   // Words in the array.

  typedef logic [DATA_W-1:0]  hdata_t;
  typedef logic [31:0]        haddr_t;
  typedef logic [BANK_AW-1:0] bank_addr_t;
  typedef logic [1:0]         htrans_t;
  typedef logic [2:0]         hsize_t;
  typedef logic [1:0]         hresp_t;
  typedef logic [3:0]         byte_en_t;  // One bit per byte lane, active high.

  localparam htrans_t HTRANS_NONSEQ = 2'd2;
  localparam htrans_t HTRANS_SEQ    = 2'd3;

  localparam hsize_t HSIZE_BYTE = 3'd0;
  localparam hsize_t HSIZE_HALF = 3'd1;
  localparam hsize_t HSIZE_WORD = 3'd2;

  localparam hresp_t HRESP_OKAY  = 2'd0;
  localparam hresp_t HRESP_ERROR = 2'd1;

  // Two-cycle ERROR response for a denied transfer.
  typedef enum logic [1:0] {
    DENY_IDLE,
    DENY_ERR_WAIT,
    DENY_ERR_LAST
  } deny_state_e;

endpackage

// ==== rtl/sms_sram_bank.sv ====
// 64 KB single-port SRAM bank with byte lane writes.
// Lane enables come from the transfer size and the low address bits.
// Read data is registered and returns zero in any cycle that follows
// a cycle without a select.
`timescale 1ns/1ps

module sms_sram_bank (
  input  logic                i_sys_hclk,
  input  logic                i_sys_rst_b,
  input  logic                i_ram_sel,
  input  logic                i_ram_write,
  input  sms_pkg::hsize_t     i_ram_size,
  input  sms_pkg::bank_addr_t i_ram_addr,
  input  sms_pkg::hdata_t     i_ram_wdata,
  output sms_pkg::hdata_t     o_ram_rdata
);

  sms_pkg::hdata_t           mem [sms_pkg::RAM_DEPTH];
  sms_pkg::hdata_t           rdata_q;
  sms_pkg::byte_en_t         byte_en;
  logic [sms_pkg::RAM_AW-1:0] word_idx;
  logic                      sel_q;

  assign word_idx = i_ram_addr[sms_pkg::BANK_AW-1:2];

  always_comb
  begin
    case (i_ram_size)
      sms_pkg::HSIZE_BYTE:
        byte_en = sms_pkg::byte_en_t'(1) << i_ram_addr[1:0];
      sms_pkg::HSIZE_HALF:
        byte_en = i_ram_addr[1] ? 4'b1100 : 4'b0011;
      sms_pkg::HSIZE_WORD:
        byte_en = 4'b1111;
      default:
        byte_en = 4'b0000;     // Unsupported size writes nothing.
    endcase
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (i_ram_sel)
    begin
      if (i_ram_write)
      begin
        for (int lane = 0; lane < $bits(sms_pkg::byte_en_t); lane++)
        begin
          if (byte_en[lane])
            mem[word_idx][lane*8 +: 8] <= i_ram_wdata[lane*8 +: 8];
        end
      end
      else
        rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      sel_q <= 1'b0;
    else
      sel_q <= i_ram_sel;
  end

  assign o_ram_rdata = sel_q ? rdata_q : '0;

  a_byte_one_lane: assert property (
    @(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    (i_ram_sel && i_ram_write && (i_ram_size == sms_pkg::HSIZE_BYTE)) |->
      $onehot(byte_en)
  );

endmodule

// ==== verification/sms_tb.sv ====
// Testbench for the AHB-Lite SRAM bank.
// Acts as the only bus master with seeded random transfers and checks each
// response against a word model of the bank. Inputs change on the rising
// edge and outputs are sampled on the falling edge.
`timescale 1ns/1ps

module sms_tb;

  localparam int N_WORDS    = 32;
  localparam int N_PARTIAL  = 24;
  localparam int N_RAW      = 16;
  localparam int N_DENY     = 8;
  localparam int N_XFERS    = 2*N_WORDS + 2*N_PARTIAL + 2*N_RAW + 4*N_DENY + 4;
  localparam int TIMEOUT_NS = N_XFERS*4*4 + 400;   // 4 cycles of 4 ns per transfer.
  localparam sms_pkg::haddr_t BASE = 32'h2000_0000;

  logic                sys_hclk;
  logic                sys_rst_b;
  logic                hsel;
  sms_pkg::htrans_t    htrans;
  logic                hwrite;
  sms_pkg::hsize_t     hsize;
  sms_pkg::haddr_t     haddr;
  sms_pkg::hdata_t     hwdata;
  logic                rd_deny;
  logic                wr_deny;
  sms_pkg::hdata_t     hrdata;
  logic                hready;
  sms_pkg::hresp_t     hresp;
  logic                idle;

  sms_pkg::hdata_t     model [int unsigned];   // Keyed by word index.
  int unsigned         words [$];
  integer              seed = 74030;
  int                  errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  sms_tb_clkgen u_clkgen (.o_sys_hclk(sys_hclk), .o_sys_rst_b(sys_rst_b));

  sms_bank_top dut (
    .i_sys_hclk (sys_hclk),
    .i_sys_rst_b(sys_rst_b),
    .i_hsel     (hsel),
    .i_htrans   (htrans),
    .i_hwrite   (hwrite),
    .i_hsize    (hsize),
    .i_haddr    (haddr),
    .i_hwdata   (hwdata),
    .i_rd_deny  (rd_deny),
    .i_wr_deny  (wr_deny),
    .o_hrdata   (hrdata),
    .o_hready   (hready),
    .o_hresp    (hresp),
    .o_idle     (idle)
  );

  // Byte by offset, halfword by address bit 1, word on all lanes.
  function automatic sms_pkg::hdata_t lane_mask(input sms_pkg::hsize_t size,
                                                input logic [1:0] off);
    case (size)
      sms_pkg::HSIZE_BYTE: lane_mask = 32'h0000_00ff << {off, 3'b000};
      sms_pkg::HSIZE_HALF: lane_mask = off[1] ? 32'hffff_0000 : 32'h0000_ffff;
      sms_pkg::HSIZE_WORD: lane_mask = 32'hffff_ffff;
      default:             lane_mask = 32'h0000_0000;
    endcase
  endfunction

  function automatic void model_write(input int unsigned word, input sms_pkg::hsize_t size,
                                      input logic [1:0] off, input sms_pkg::hdata_t wdata);
    sms_pkg::hdata_t m;
    sms_pkg::hdata_t old;
    m = lane_mask(size, off);
    old = model.exists(word) ? model[word] : 32'h0;
    model[word] = (old & ~m) | (wdata & m);
  endfunction

  function automatic int unsigned pick_word();
    int unsigned r;
    r = $unsigned($random(seed));
    return words[r % words.size()];
  endfunction

  task automatic drive_addr(input logic write, input sms_pkg::hsize_t size,
                            input int unsigned word, input logic [1:0] off, input logic deny);
    @(posedge sys_hclk);
    hsel    <= 1'b1;
    htrans  <= sms_pkg::HTRANS_NONSEQ;
    hwrite  <= write;
    hsize   <= size;
    haddr   <= BASE | {16'd0, word[13:0], off};
    wr_deny <= write && deny;
    rd_deny <= !write && deny;
  endtask

  // Follows the data phase until hready is high and counts the wait cycles.
  task automatic data_phase(output int n_wait, output sms_pkg::hresp_t resp_wait);
    n_wait = 0;
    resp_wait = sms_pkg::HRESP_OKAY;
    @(negedge sys_hclk);
    while (!hready && n_wait < 8)
    begin
      resp_wait = hresp;
      n_wait++;
      @(negedge sys_hclk);
    end
    if (!hready)
    begin
      $display("Data phase did not end within 8 wait cycles");
      errors++;
    end
  endtask

  task automatic xfer(input logic write, input sms_pkg::hsize_t size, input int unsigned word,
                      input logic [1:0] off, input sms_pkg::hdata_t wdata, input logic deny);
    int              n_wait;
    int              exp_wait;
    sms_pkg::hresp_t resp_wait;
    sms_pkg::hresp_t exp_resp;
    drive_addr(write, size, word, off, deny);
    @(negedge sys_hclk);
    if (hready !== 1'b1)
    begin
      $display("Mismatch o_hready in address phase: got 0x%h, expected 0x1", hready);
      errors++;
    end
    if (!deny && idle !== 1'b0)
    begin
      $display("Mismatch o_idle in address phase: got 0x%h, expected 0x0", idle);
      errors++;
    end
    @(posedge sys_hclk);
    hsel    <= 1'b0;
    htrans  <= 2'd0;
    wr_deny <= 1'b0;
    rd_deny <= 1'b0;
    hwdata  <= wdata;
    data_phase(n_wait, resp_wait);
    if (write && !deny)
      model_write(word, size, off, wdata);
    exp_wait = deny ? 1 : 0;
    exp_resp = deny ? sms_pkg::HRESP_ERROR : sms_pkg::HRESP_OKAY;
    if (n_wait != exp_wait)
    begin
      $display("Word 0x%h held hready low for %0d cycles, expected %0d", word, n_wait, exp_wait);
      errors++;
    end
    if (deny && resp_wait !== sms_pkg::HRESP_ERROR)
    begin
      $display("Mismatch o_hresp in first cycle: got 0x%h, expected 0x1", resp_wait);
      errors++;
    end
    if (hresp !== exp_resp)
    begin
      $display("Mismatch o_hresp: got 0x%h, expected 0x%h", hresp, exp_resp);
      errors++;
    end
    if (!write && !deny && hrdata !== model[word])
    begin
      $display("Mismatch o_hrdata at word 0x%h: got 0x%h, expected 0x%h",
               word, hrdata, model[word]);
      errors++;
    end
  endtask

  // Read address phase right behind a write address phase.
  task automatic write_then_read(input sms_pkg::hsize_t size, input int unsigned wword,
                                 input logic [1:0] off, input sms_pkg::hdata_t wdata,
                                 input int unsigned rword);
    int              n_wait;
    sms_pkg::hresp_t resp_wait;
    drive_addr(1'b1, size, wword, off, 1'b0);
    drive_addr(1'b0, sms_pkg::HSIZE_WORD, rword, 2'd0, 1'b0);
    hwdata <= wdata;
    @(negedge sys_hclk);
    if (hready !== 1'b1)
    begin
      $display("Mismatch o_hready in read address phase: got 0x%h, expected 0x1", hready);
      errors++;
    end
    if (idle !== 1'b0)
    begin
      $display("Mismatch o_idle in read address phase: got 0x%h, expected 0x0", idle);
      errors++;
    end
    @(posedge sys_hclk);
    hsel   <= 1'b0;
    htrans <= 2'd0;
    model_write(wword, size, off, wdata);
    data_phase(n_wait, resp_wait);
    if (n_wait != 1)
    begin
      $display("Read after write held hready low for %0d cycles, expected 1", n_wait);
      errors++;
    end
    if (resp_wait !== sms_pkg::HRESP_OKAY)
    begin
      $display("Mismatch o_hresp in wait cycle: got 0x%h, expected 0x0", resp_wait);
      errors++;
    end
    if (hresp !== sms_pkg::HRESP_OKAY)
    begin
      $display("Mismatch o_hresp: got 0x%h, expected 0x0", hresp);
      errors++;
    end
    if (hrdata !== model[rword])
    begin
      $display("Mismatch o_hrdata at word 0x%h: got 0x%h, expected 0x%h",
               rword, hrdata, model[rword]);
      errors++;
    end
  endtask

  task automatic idle_cycle();
    @(posedge sys_hclk);
    @(negedge sys_hclk);
    if (idle !== 1'b1)
    begin
      $display("Mismatch o_idle in idle cycle: got 0x%h, expected 0x1", idle);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start);
    int    n;
    string verdict;
    n = errors - start;
    tests_run++;
    verdict = "ok";
    if (n != 0)
    begin
      tests_failed++;
      verdict = "failed";
    end
    $display("Test %0d %s: %s, %0d errors", tests_run, name, verdict, n);
  endtask

  initial
  begin
    #TIMEOUT_NS;
    $display("Watchdog ended the run after %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int                start;
    int                reset_errs;
    int unsigned       w;
    logic [31:0]       r;
    sms_pkg::hsize_t   size;
    logic [1:0]        off;
    hsel    <= 1'b0;
    htrans  <= 2'd0;
    hwrite  <= 1'b0;
    hsize   <= sms_pkg::HSIZE_WORD;
    haddr   <= BASE;
    hwdata  <= 32'h0;
    rd_deny <= 1'b0;
    wr_deny <= 1'b0;
    wait (sys_rst_b === 1'b1);
    @(negedge sys_hclk);
    if (hready !== 1'b1)
    begin
      $display("Mismatch o_hready after reset: got 0x%h, expected 0x1", hready);
      errors++;
    end
    if (hresp !== sms_pkg::HRESP_OKAY)
    begin
      $display("Mismatch o_hresp after reset: got 0x%h, expected 0x0", hresp);
      errors++;
    end
    if (idle !== 1'b1)
    begin
      $display("Mismatch o_idle after reset: got 0x%h, expected 0x1", idle);
      errors++;
    end
    reset_errs = errors;

    start = errors;
    for (int i = 0; i < N_WORDS; i++)
    begin
      w = $unsigned($random(seed)) % sms_pkg::RAM_DEPTH;
      words.push_back(w);
      xfer(1'b1, sms_pkg::HSIZE_WORD, w, 2'd0, $random(seed), 1'b0);
      idle_cycle();
    end
    for (int i = 0; i < N_WORDS; i++)
    begin
      xfer(1'b0, sms_pkg::HSIZE_WORD, pick_word(), 2'd0, 32'h0, 1'b0);
      idle_cycle();
    end
    report_test("word round trip", start);

    start = errors;
    for (int i = 0; i < N_PARTIAL; i++)
    begin
      r = $random(seed);
      w = pick_word();
      size = r[0] ? sms_pkg::HSIZE_HALF : sms_pkg::HSIZE_BYTE;
      off = r[0] ? {r[1], 1'b0} : r[2:1];
      xfer(1'b1, size, w, off, $random(seed), 1'b0);
      idle_cycle();
      xfer(1'b0, sms_pkg::HSIZE_WORD, w, 2'd0, 32'h0, 1'b0);
      idle_cycle();
    end
    report_test("partial writes", start);

    start = errors;
    for (int i = 0; i < N_RAW; i++)
    begin
      r = $random(seed);
      w = pick_word();
      size = r[0] ? sms_pkg::HSIZE_HALF : sms_pkg::HSIZE_BYTE;
      if (r[3])
        size = sms_pkg::HSIZE_WORD;
      off = r[0] ? {r[1], 1'b0} : r[2:1];
      if (r[3])
        off = 2'd0;
      write_then_read(size, w, off, $random(seed), r[4] ? w : pick_word());
      idle_cycle();
    end
    report_test("read after write", start);

    start = errors;
    for (int i = 0; i < N_DENY; i++)
    begin
      w = pick_word();
      xfer(1'b1, sms_pkg::HSIZE_WORD, w, 2'd0, $random(seed), 1'b1);
      idle_cycle();
      xfer(1'b0, sms_pkg::HSIZE_WORD, w, 2'd0, 32'h0, 1'b0);
      idle_cycle();
    end
    report_test("write deny", start);

    start = errors;
    for (int i = 0; i < N_DENY; i++)
    begin
      w = pick_word();
      xfer(1'b0, sms_pkg::HSIZE_WORD, w, 2'd0, 32'h0, 1'b1);
      idle_cycle();
      xfer(1'b0, sms_pkg::HSIZE_WORD, w, 2'd0, 32'h0, 1'b0);
      idle_cycle();
    end
    report_test("read deny", start);

    start = errors - reset_errs;    // Reset state counts toward this test.
    repeat (3) idle_cycle();
    xfer(1'b0, sms_pkg::HSIZE_WORD, pick_word(), 2'd0, 32'h0, 1'b0);
    idle_cycle();
    report_test("idle", start);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verification/sms_tb_clkgen.sv ====
// Clock and reset source for the SRAM bank testbench.
// Gives a 4 ns clock and holds reset low for the first two cycles.
`timescale 1ns/1ps

module sms_tb_clkgen (
  output logic o_sys_hclk,
  output logic o_sys_rst_b
);

  localparam int HALF_NS    = 2;
  localparam int RST_CYCLES = 2;

  initial
  begin
    o_sys_hclk = 1'b0;
    forever #HALF_NS o_sys_hclk = ~o_sys_hclk;
  end

  initial
  begin
    o_sys_rst_b <= 1'b0;
    repeat (RST_CYCLES) @(posedge o_sys_hclk);
    o_sys_rst_b <= 1'b1;     // Released on a rising edge.
  end

endmodule

// ==== vlog.f ====
rtl/sms_pkg.sv
rtl/sms_deny_filter.sv
rtl/sms_ahb_ctrl.sv
rtl/sms_sram_bank.sv
rtl/sms_bank_top.sv
verification/sms_tb_clkgen.sv
verification/sms_tb.sv
